//--- common/vmem_pkg.sv
`default_nettype none

package vmem_pkg;

    localparam int VECTOR_LANES = 16;
    localparam int LANE_WIDTH   = 32;
    localparam int LANE_IDX_W   = $clog2(VECTOR_LANES);
    localparam int ADDR_WIDTH   = 16;
    localparam int MAT_WORDS    = 9;

    // address map
    localparam logic [ADDR_WIDTH-1:0] REGION_MASK = 16'hF000;
    localparam logic [ADDR_WIDTH-1:0] DATA_BASE   = 16'h0000;
    localparam logic [ADDR_WIDTH-1:0] TEXT_BASE   = 16'h1000;
    localparam logic [ADDR_WIDTH-1:0] MAT_L_ADDR  = 16'h1200;
    localparam logic [ADDR_WIDTH-1:0] MAT_U_ADDR  = 16'h1201;

    typedef logic [VECTOR_LANES-1:0][LANE_WIDTH-1:0] lane_vec_t;
    typedef logic [MAT_WORDS-1:0][LANE_WIDTH-1:0]    mat_vec_t;

    typedef enum logic [2:0] {
        W_FULL = 3'd0,
        W32    = 3'd1,
        W64    = 3'd2,
        W128   = 3'd3,
        W256   = 3'd4
    } mem_width_e;

    typedef enum logic [2:0] {
        REG_DATA,
        REG_TEXT,
        REG_MAT_L,
        REG_MAT_U,
        REG_NONE
    } mem_region_e;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0]   addr;
        logic                    we;
        logic                    ren;
        mem_width_e              width;
        logic [VECTOR_LANES-1:0] wmask;
    } mem_req_t;

    typedef struct packed {
        logic                  valid;
        mem_region_e           region;
        logic [LANE_IDX_W-1:0] offset;
        mem_width_e            width;
    } rsp_tag_t;

    // lanes covered by one access, codes 5-7 count as full
    function automatic logic [LANE_IDX_W:0] lane_count(mem_width_e w);
        case (w)
            W32:     return 5'd1;
            W64:     return 5'd2;
            W128:    return 5'd4;
            W256:    return 5'd8;
            default: return 5'd16;
        endcase
    endfunction

    // full rows always start at lane 0
    function automatic logic [LANE_IDX_W-1:0] lane_offset(logic [LANE_IDX_W-1:0] low,
                                                          mem_width_e w);
        return (lane_count(w) == 5'd16) ? '0 : low;
    endfunction

endpackage

`default_nettype wire

//--- hdl/mem_req_stage.sv
`default_nettype none

module mem_req_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [vmem_pkg::ADDR_WIDTH-1:0] mem_addr,
    input  logic                           mem_we,
    input  logic                           mem_ren,
    input  vmem_pkg::lane_vec_t            mem_wdata,
    input  vmem_pkg::mem_width_e           width,
    output vmem_pkg::mem_req_t             req,
    output vmem_pkg::lane_vec_t            req_wdata
);
    import vmem_pkg::*;

    logic [LANE_IDX_W:0]     lanes;
    logic [LANE_IDX_W-1:0]   start;
    logic [VECTOR_LANES-1:0] span;
    logic [VECTOR_LANES-1:0] wmask_d;
    lane_vec_t               wdata_d;

    logic                    we_q;
    logic                    ren_q;
    logic [ADDR_WIDTH-1:0]   addr_q;
    mem_width_e              width_q;
    logic [VECTOR_LANES-1:0] wmask_q;

    assign lanes = lane_count(width);
    assign start = lane_offset(mem_addr[LANE_IDX_W-1:0], width);

    assign span    = {VECTOR_LANES{1'b1}} >> (VECTOR_LANES - lanes);  // lanes ones, low end
    assign wmask_d = span << start;  // bits past lane 15 fall off

    // core lane 0 lands on the start lane
    assign wdata_d = mem_wdata << (LANE_WIDTH * start);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_q  <= 1'b0;
            ren_q <= 1'b0;
        end else begin
            we_q  <= mem_we;
            ren_q <= mem_ren;
        end
    end

    always_ff @(posedge clk) begin
        addr_q    <= mem_addr;
        width_q   <= width;
        wmask_q   <= wmask_d;
        req_wdata <= wdata_d;
    end

    assign req = '{
        addr:  addr_q,
        we:    we_q,
        ren:   ren_q,
        width: width_q,
        wmask: wmask_q
    };

endmodule

`default_nettype wire

//--- memory_controller/memory_controller.sv
`default_nettype none

module memory_controller #(
    parameter int INSTR_MEM_ADDR_WIDTH = 8,
    parameter int DATA_MEM_ADDR_WIDTH  = 8
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  vmem_pkg::mem_req_t                req,
    input  vmem_pkg::lane_vec_t               req_wdata,
    // instruction memory
    output logic [INSTR_MEM_ADDR_WIDTH-1:0]   instr_mem_addr,
    output logic                              instr_mem_csb,
    output logic                              instr_mem_web,
    output logic [vmem_pkg::LANE_WIDTH-1:0]   instr_mem_wdata,
    // data memory
    output logic [DATA_MEM_ADDR_WIDTH-1:0]    data_mem_addr,
    output logic                              data_mem_csb,
    output logic                              data_mem_web,
    output logic [vmem_pkg::VECTOR_LANES-1:0] data_mem_wmask,
    output vmem_pkg::lane_vec_t               data_mem_wdata,
    output vmem_pkg::rsp_tag_t                tag
);
    import vmem_pkg::*;

    mem_region_e           region;
    logic                  req_any;
    logic                  req_read;
    logic [LANE_IDX_W-1:0] start;

    logic                  tag_valid_q;
    mem_region_e           tag_region_q;
    logic [LANE_IDX_W-1:0] tag_offset_q;
    mem_width_e            tag_width_q;

    // exact matrix words win over the text range
    always_comb begin
        if (req.addr == MAT_L_ADDR) begin
            region = REG_MAT_L;
        end else if (req.addr == MAT_U_ADDR) begin
            region = REG_MAT_U;
        end else if ((req.addr & REGION_MASK) == DATA_BASE) begin
            region = REG_DATA;
        end else if ((req.addr & REGION_MASK) == TEXT_BASE) begin
            region = REG_TEXT;
        end else begin
            region = REG_NONE;
        end
    end

    assign req_any  = req.we | req.ren;
    assign req_read = req.ren & ~req.we;  // write wins when both set
    assign start    = lane_offset(req.addr[LANE_IDX_W-1:0], req.width);

    assign instr_mem_addr  = req.addr[INSTR_MEM_ADDR_WIDTH-1:0];  // aliases by depth
    assign instr_mem_csb   = req_any & (region == REG_TEXT);
    assign instr_mem_web   = req.we & (region == REG_TEXT);
    assign instr_mem_wdata = req_wdata[start];  // undo the store shift

    assign data_mem_addr  = req.addr[LANE_IDX_W +: DATA_MEM_ADDR_WIDTH];
    assign data_mem_csb   = req_any & (region == REG_DATA);
    assign data_mem_web   = req.we & (region == REG_DATA);
    assign data_mem_wmask = req.wmask;
    assign data_mem_wdata = req_wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_valid_q <= 1'b0;
        end else begin
            tag_valid_q <= req_read;
        end
    end

    always_ff @(posedge clk) begin
        tag_region_q <= region;
        tag_offset_q <= start;
        tag_width_q  <= req.width;
    end

    assign tag = '{
        valid:  tag_valid_q,
        region: tag_region_q,
        offset: tag_offset_q,
        width:  tag_width_q
    };

endmodule

`default_nettype wire

//--- memory_controller/rdata_align.sv
`default_nettype none

module rdata_align (
    input  vmem_pkg::rsp_tag_t              tag,
    input  logic [vmem_pkg::LANE_WIDTH-1:0] instr_mem_rdata,
    input  vmem_pkg::lane_vec_t             data_mem_rdata,
    input  vmem_pkg::mat_vec_t              mat_inv_in_l,
    input  vmem_pkg::mat_vec_t              mat_inv_in_u,
    output vmem_pkg::lane_vec_t             rdata,
    output logic                            rdata_valid
);
    import vmem_pkg::*;

    logic [LANE_IDX_W:0] lanes;
    lane_vec_t           data_shifted;
    lane_vec_t           data_aligned;

    assign lanes = lane_count(tag.width);

    // start lane moves down to lane 0, zeros come in from the top
    assign data_shifted = data_mem_rdata >> (LANE_WIDTH * tag.offset);

    always_comb begin
        data_aligned = '0;
        for (int i = 0; i < VECTOR_LANES; i++) begin
            if (i < lanes) begin
                data_aligned[i] = data_shifted[i];
            end
        end
    end

    always_comb begin
        rdata = '0;
        case (tag.region)
            REG_DATA: begin
                rdata = data_aligned;
            end
            REG_TEXT: begin
                rdata[0] = instr_mem_rdata;
            end
            REG_MAT_L: begin
                rdata[MAT_WORDS-1:0] = mat_inv_in_l;
            end
            REG_MAT_U: begin
                rdata[MAT_WORDS-1:0] = mat_inv_in_u;
            end
            default: begin
                rdata = '0;  // unmapped
            end
        endcase
    end

    assign rdata_valid = tag.valid;

endmodule

`default_nettype wire

//--- hdl/instr_sram.sv
`default_nettype none

module instr_sram #(
    parameter int INSTR_MEM_ADDR_WIDTH = 8
) (
    input  logic                            clk,
    input  logic [INSTR_MEM_ADDR_WIDTH-1:0] addr,
    input  logic                            csb,
    input  logic                            web,
    input  logic [vmem_pkg::LANE_WIDTH-1:0] wdata,
    output logic [vmem_pkg::LANE_WIDTH-1:0] rdata
);
    import vmem_pkg::*;

    localparam int DEPTH = 2 ** INSTR_MEM_ADDR_WIDTH;

    logic [LANE_WIDTH-1:0] mem [DEPTH];

    // enables are active high despite the names
    always_ff @(posedge clk) begin
        if (csb) begin
            if (web) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];  // held until the next read
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/data_sram.sv
`default_nettype none

module data_sram #(
    parameter int DATA_MEM_ADDR_WIDTH = 8
) (
    input  logic                              clk,
    input  logic [DATA_MEM_ADDR_WIDTH-1:0]    addr,
    input  logic                              csb,
    input  logic                              web,
    input  logic [vmem_pkg::VECTOR_LANES-1:0] wmask,
    input  vmem_pkg::lane_vec_t               wdata,
    output vmem_pkg::lane_vec_t               rdata
);
    import vmem_pkg::*;

    localparam int DEPTH = 2 ** DATA_MEM_ADDR_WIDTH;

    lane_vec_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (csb) begin
            if (web) begin
                for (int i = 0; i < VECTOR_LANES; i++) begin
                    if (wmask[i]) begin
                        mem[addr][i] <= wdata[i];  // masked lanes only
                    end
                end
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/vmem_subsystem.sv
`default_nettype none

module vmem_subsystem #(
    parameter int INSTR_MEM_ADDR_WIDTH = 8,
    parameter int DATA_MEM_ADDR_WIDTH  = 8
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [vmem_pkg::ADDR_WIDTH-1:0] mem_addr,
    input  logic                            mem_we,
    input  logic                            mem_ren,
    input  vmem_pkg::lane_vec_t             mem_wdata,
    input  vmem_pkg::mem_width_e            width,
    input  vmem_pkg::mat_vec_t              mat_inv_in_l,
    input  vmem_pkg::mat_vec_t              mat_inv_in_u,
    output vmem_pkg::lane_vec_t             rdata,
    output logic                            rdata_valid
);
    import vmem_pkg::*;

    mem_req_t                      req;
    lane_vec_t                     req_wdata;
    rsp_tag_t                      tag;

    logic [INSTR_MEM_ADDR_WIDTH-1:0] instr_mem_addr;
    logic                          instr_mem_csb;
    logic                          instr_mem_web;
    logic [LANE_WIDTH-1:0]         instr_mem_wdata;
    logic [LANE_WIDTH-1:0]         instr_mem_rdata;

    logic [DATA_MEM_ADDR_WIDTH-1:0] data_mem_addr;
    logic                          data_mem_csb;
    logic                          data_mem_web;
    logic [VECTOR_LANES-1:0]       data_mem_wmask;
    lane_vec_t                     data_mem_wdata;
    lane_vec_t                     data_mem_rdata;

    mem_req_stage u_req_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_addr  (mem_addr),
        .mem_we    (mem_we),
        .mem_ren   (mem_ren),
        .mem_wdata (mem_wdata),
        .width     (width),
        .req       (req),
        .req_wdata (req_wdata)
    );

    memory_controller #(
        .INSTR_MEM_ADDR_WIDTH (INSTR_MEM_ADDR_WIDTH),
        .DATA_MEM_ADDR_WIDTH  (DATA_MEM_ADDR_WIDTH)
    ) u_memory_controller (
        .clk             (clk),
        .rst_n           (rst_n),
        .req             (req),
        .req_wdata       (req_wdata),
        .instr_mem_addr  (instr_mem_addr),
        .instr_mem_csb   (instr_mem_csb),
        .instr_mem_web   (instr_mem_web),
        .instr_mem_wdata (instr_mem_wdata),
        .data_mem_addr   (data_mem_addr),
        .data_mem_csb    (data_mem_csb),
        .data_mem_web    (data_mem_web),
        .data_mem_wmask  (data_mem_wmask),
        .data_mem_wdata  (data_mem_wdata),
        .tag             (tag)
    );

    instr_sram #(
        .INSTR_MEM_ADDR_WIDTH (INSTR_MEM_ADDR_WIDTH)
    ) u_instr_sram (
        .clk   (clk),
        .addr  (instr_mem_addr),
        .csb   (instr_mem_csb),
        .web   (instr_mem_web),
        .wdata (instr_mem_wdata),
        .rdata (instr_mem_rdata)
    );

    data_sram #(
        .DATA_MEM_ADDR_WIDTH (DATA_MEM_ADDR_WIDTH)
    ) u_data_sram (
        .clk   (clk),
        .addr  (data_mem_addr),
        .csb   (data_mem_csb),
        .web   (data_mem_web),
        .wmask (data_mem_wmask),
        .wdata (data_mem_wdata),
        .rdata (data_mem_rdata)
    );

    rdata_align u_rdata_align (
        .tag             (tag),
        .instr_mem_rdata (instr_mem_rdata),
        .data_mem_rdata  (data_mem_rdata),
        .mat_inv_in_l    (mat_inv_in_l),
        .mat_inv_in_u    (mat_inv_in_u),
        .rdata           (rdata),
        .rdata_valid     (rdata_valid)
    );

endmodule

`default_nettype wire

//--- dv/vmem_properties.sv
`default_nettype none

module vmem_properties (
    input logic                              clk,
    input logic                              rst_n,
    input vmem_pkg::mem_req_t                req,
    input logic                              instr_mem_csb,
    input logic                              instr_mem_web,
    input logic                              data_mem_csb,
    input logic                              data_mem_web,
    input logic [vmem_pkg::VECTOR_LANES-1:0] data_mem_wmask,
    input vmem_pkg::rsp_tag_t                tag
);
    int unsigned fail_count = 0;

    one_memory_at_a_time: assert property (@(posedge clk) disable iff (!rst_n)
        !(instr_mem_csb && data_mem_csb))
        else begin
            fail_count++;
            $error("instruction and data memory enabled together");
        end

    // write enables never without the matching enable
    write_needs_enable: assert property (@(posedge clk) disable iff (!rst_n)
        (!instr_mem_web || instr_mem_csb) && (!data_mem_web || data_mem_csb))
        else begin
            fail_count++;
            $error("memory write enable high without its enable");
        end

    data_mask_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        data_mem_web |-> (data_mem_wmask != '0))
        else begin
            fail_count++;
            $error("data memory write with an empty lane mask");
        end

    tag_follows_read: assert property (@(posedge clk) disable iff (!rst_n)
        tag.valid == $past(req.ren && !req.we))
        else begin
            fail_count++;
            $error("tag valid does not follow the read request by one cycle");
        end

endmodule

`default_nettype wire

//--- dv/vmem_tb.sv
`default_nettype none

module vmem_tb;
    import vmem_pkg::*;

    localparam int IW        = 8;
    localparam int DW        = 8;
    localparam int DRAIN_MAX = 16;  // idle cycles
    localparam int MIX_OPS   = 3000;
    localparam int R_DATA    = 0;
    localparam int R_TEXT    = 1;
    localparam int R_MAT_L   = 2;
    localparam int R_MAT_U   = 3;
    localparam int R_NONE    = 4;

    logic                  clk;
    logic                  rst_n;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic                  mem_we;
    logic                  mem_ren;
    lane_vec_t             mem_wdata;
    mem_width_e            width;
    mat_vec_t              mat_l;
    mat_vec_t              mat_u;
    lane_vec_t             rdata;
    logic                  rdata_valid;

    lane_vec_t             model_data [2**DW];
    logic [LANE_WIDTH-1:0] model_instr [2**IW];
    lane_vec_t             exp_data_q [$];
    int                    exp_cyc_q [$];

    logic [31:0] lfsr   = 32'h1dc8_9375;
    int          cyc    = 0;
    int          checks = 0;
    int          errors = 0;

    vmem_subsystem #(
        .INSTR_MEM_ADDR_WIDTH (IW),
        .DATA_MEM_ADDR_WIDTH  (DW)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_addr     (mem_addr),
        .mem_we       (mem_we),
        .mem_ren      (mem_ren),
        .mem_wdata    (mem_wdata),
        .width        (width),
        .mat_inv_in_l (mat_l),
        .mat_inv_in_u (mat_u),
        .rdata        (rdata),
        .rdata_valid  (rdata_valid)
    );

    bind memory_controller vmem_properties u_props (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (req),
        .instr_mem_csb  (instr_mem_csb),
        .instr_mem_web  (instr_mem_web),
        .data_mem_csb   (data_mem_csb),
        .data_mem_web   (data_mem_web),
        .data_mem_wmask (data_mem_wmask),
        .tag            (tag)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic lane_vec_t rand_lanes();
        lane_vec_t v;
        for (int i = 0; i < VECTOR_LANES; i++) begin
            v[i] = rand_bits(32);
        end
        return v;
    endfunction

    function automatic mat_vec_t rand_mat();
        mat_vec_t v;
        for (int i = 0; i < MAT_WORDS; i++) begin
            v[i] = rand_bits(32);
        end
        return v;
    endfunction

    function automatic int region_of(input logic [15:0] a);
        if (a == 16'h1200) return R_MAT_L;  // exact words before the text range
        if (a == 16'h1201) return R_MAT_U;
        if (a[15:12] == 4'h0) return R_DATA;
        if (a[15:12] == 4'h1) return R_TEXT;
        return R_NONE;
    endfunction

    function automatic int lanes_for_code(input logic [2:0] code);
        case (code)
            3'd1:    return 1;
            3'd2:    return 2;
            3'd3:    return 4;
            3'd4:    return 8;
            default: return 16;
        endcase
    endfunction

    task automatic compare(input string name, input logic [511:0] got, input logic [511:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic model_access(input logic [15:0] addr, input logic we, input logic ren,
                                input logic [2:0] code, input lane_vec_t wdata);
        int        kind;
        int        cnt;
        int        off;
        lane_vec_t exp;
        kind = region_of(addr);
        cnt  = lanes_for_code(code);
        off  = (cnt == 16) ? 0 : int'(addr[3:0]);
        exp  = '0;
        if (we) begin
            for (int i = 0; i < cnt && kind == R_DATA; i++) begin
                if (off + i < VECTOR_LANES) model_data[addr[4 +: DW]][off + i] = wdata[i];
            end
            if (kind == R_TEXT) model_instr[addr[IW-1:0]] = wdata[0];
        end else if (ren) begin
            for (int i = 0; i < cnt && kind == R_DATA; i++) begin
                if (off + i < VECTOR_LANES) exp[i] = model_data[addr[4 +: DW]][off + i];
            end
            if (kind == R_TEXT) exp[0] = model_instr[addr[IW-1:0]];
            if (kind == R_MAT_L) exp[MAT_WORDS-1:0] = mat_l;
            if (kind == R_MAT_U) exp[MAT_WORDS-1:0] = mat_u;
            exp_data_q.push_back(exp);
            exp_cyc_q.push_back(cyc + 2);  // sampled next edge, data one edge later
        end
    endtask

    task automatic check_response();
        if (rdata_valid) begin
            if (exp_data_q.size() == 0) begin
                errors++;
                $display("ERROR at %0t: rdata_valid high with no read outstanding", $time);
            end else begin
                compare("rdata", rdata, exp_data_q.pop_front());
                compare("rdata_valid cycle", 512'(cyc), 512'(exp_cyc_q.pop_front()));
            end
        end else if (exp_cyc_q.size() != 0 && exp_cyc_q[0] <= cyc) begin
            errors++;
            $display("ERROR at %0t: read response due in cycle %0d never came",
                     $time, exp_cyc_q[0]);
            void'(exp_data_q.pop_front());
            void'(exp_cyc_q.pop_front());
        end
    endtask

    // one request per cycle, response checked mid-cycle
    task automatic tick(input logic [15:0] addr, input logic we, input logic ren,
                        input logic [2:0] code, input lane_vec_t wdata);
        @(posedge clk);
        #2;
        mem_addr  = addr;
        mem_we    = we;
        mem_ren   = ren;
        width     = mem_width_e'(code);
        mem_wdata = wdata;
        model_access(addr, we, ren, code, wdata);
        @(negedge clk);
        check_response();
    endtask

    task automatic idle(input int n);
        repeat (n) tick(16'h0000, 1'b0, 1'b0, 3'd0, '0);
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_cyc_q.size() != 0 && n < DRAIN_MAX) begin
            idle(1);
            n++;
        end
        if (exp_cyc_q.size() != 0) begin
            errors++;
            $display("ERROR at %0t: %0d read responses missing after %0d idle cycles",
                     $time, exp_cyc_q.size(), DRAIN_MAX);
            exp_data_q.delete();
            exp_cyc_q.delete();
        end
    endtask

    initial begin
        logic [15:0] a;
        logic [31:0] sb;
        int          pick;
        int unsigned afails;
        rst_n     = 1'b0;
        mem_addr  = '0;
        mem_we    = 1'b0;
        mem_ren   = 1'b0;
        mem_wdata = '0;
        width     = W_FULL;
        mat_l     = rand_mat();
        mat_u     = rand_mat();
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        idle(12);  // no response may show up

        // fill both memories so no read sees x
        for (int r = 0; r < 2**DW; r++) begin
            tick(16'(r * 16 + rand_bits(4)), 1'b1, 1'b0, 3'd0, rand_lanes());
        end
        for (int i = 0; i < 2**IW; i++) begin
            tick(16'(32'h1000 + i), 1'b1, 1'b0, 3'(rand_bits(3)), rand_lanes());
        end
        for (int r = 0; r < 2**DW; r++) tick(16'(r * 16), 1'b0, 1'b1, 3'd0, '0);  // back to back
        for (int k = 0; k < 24; k++) begin
            a = 16'(rand_bits(12));
            tick(a, 1'b1, 1'b0, 3'(5 + k % 3), rand_lanes());
            tick(a, 1'b0, 1'b1, 3'(5 + (k + 1) % 3), '0);
        end

        // narrow stores and loads, clipping near lane 15
        for (int k = 0; k < 400; k++) begin
            pick = int'(rand_bits(1));
            tick(16'(rand_bits(12)), pick == 1, pick == 0, 3'(1 + rand_bits(2)), rand_lanes());
        end

        // instruction words through aliased addresses
        for (int k = 0; k < 64; k++) begin
            sb = rand_bits(8);
            a  = 16'(32'h1000 + (rand_bits(4) << 8) + sb);
            tick(a, 1'b1, 1'b0, 3'(rand_bits(3)), rand_lanes());
            a  = 16'(32'h1000 + (rand_bits(4) << 8) + sb);
            tick(a, 1'b0, 1'b1, 3'(rand_bits(3)), '0);
        end

        drain();
        mat_l = rand_mat();
        mat_u = rand_mat();
        for (int k = 0; k < 16; k++) begin
            tick(16'h1200 + 16'(k % 2), 1'b0, 1'b1, 3'(rand_bits(3)), '0);
            tick(16'h1200 + 16'(k % 2), 1'b1, 1'b0, 3'(rand_bits(3)), rand_lanes());
            tick(16'h1000 + 16'(k % 2), 1'b0, 1'b1, 3'd1, '0);
            a = 16'(rand_bits(16)) | 16'h2000;  // unmapped
            tick(a, 1'b1, 1'b0, 3'(rand_bits(3)), rand_lanes());
            tick(a, 1'b0, 1'b1, 3'(rand_bits(3)), '0);
            tick(a & 16'h0FFF, 1'b0, 1'b1, 3'd0, '0);
            tick((a & 16'h00FF) | 16'h1000, 1'b0, 1'b1, 3'd1, '0);
        end

        // long mix of every region, width and strobe pair
        for (int k = 0; k < MIX_OPS; k++) begin
            pick = int'(rand_bits(3));
            case (pick)
                0, 1, 2: a = 16'(rand_bits(12));
                3, 4:    a = 16'(32'h1000 + rand_bits(12));
                5:       a = 16'(32'h1200 + rand_bits(1));
                6:       a = 16'(rand_bits(16)) | 16'h2000;
                default: a = 16'(rand_bits(16));
            endcase
            sb = rand_bits(2);
            tick(a, sb[1], sb[0], 3'(rand_bits(3)), rand_lanes());
        end

        drain();
        idle(4);
        afails = UUT.u_memory_controller.u_props.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, afails);
        if (errors == 0 && afails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vmem_subsystem.f
common/vmem_pkg.sv
hdl/mem_req_stage.sv
memory_controller/memory_controller.sv
memory_controller/rdata_align.sv
hdl/instr_sram.sv
hdl/data_sram.sv
hdl/vmem_subsystem.sv
dv/vmem_properties.sv
dv/vmem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the vmem testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module vmem_tb -Mdir obj_dir -f vmem_subsystem.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running after an assertion error so the testbench can report it
output=$(./obj_dir/Vvmem_tb +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx '>>> PASS' <<< "$output"; then
    exit 0
else
    exit 1
fi
